//--- Makefile
VERILATOR ?= verilator
TOP       ?= cw_io_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= project.f
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := include/cw_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/cw_params.svh
`ifndef CW_PARAMS_SVH
`define CW_PARAMS_SVH

// register map
`define CW_EXTCLK_ADDR   6'd38         // clock select, one byte
`define CW_TRIGSRC_ADDR  6'd39         // trigger sources and combine mode
`define CW_TRIGMOD_ADDR  6'd40         // trigger module and front-panel out enables
`define CW_IOROUTE_ADDR  6'd55         // 8-byte target i/o routing
`define CW_IOREAD_ADDR   6'd59         // sampled target lines, read only

// bus widths
`define CW_ADDR_W        6
`define CW_DATA_W        8
`define CW_CNT_W         16            // byte count within a multi-byte register
`define CW_LEN_W         16            // register length answer

`define CW_ROUTE_BYTES   8
`define CW_IO_LINES      4
`define CW_TRIG_SRCS     6             // fpa, fpb, line 1..4

// reset values
`define CW_EXTCLK_RST    8'h03
`define CW_TRIGSRC_RST   8'h01         // fpa enabled, or mode
`define CW_TRIGMOD_RST   8'h00
`define CW_ROUTE_RST     64'h0000_0000_0000_0201 // line 1 tx, line 2 rx

// soft-start pwm
`define CW_PWM_W         4             // pwm counter width, period 16 clocks
`define CW_PWM_OFF       11            // power held off while pwm count is below this
`define CW_SOFT_W        3             // ramp length in pwm periods

`endif

//--- logic/clk_route.sv
`timescale 1ns/1ns

module clk_route (
	input  cw_pkg::cw_extclk_t extclk_i,
	input  logic               trigger_i,     // final trigger, may drive fpa
	input  logic               fpb_clk_i,
	input  logic               pll_clk_i,
	input  logic               rear_clk_i,
	input  logic               clkgen_i,
	input  logic               glitchclk_i,
	output logic               extclk_o,      // fabric clock source
	output cw_pkg::cw_pin_t    fpa_clk_pin_o
);
	import cw_pkg::*;

	// plain fabric mux, no phase relation assumed between sources
	always_comb begin
		case (extclk_i.src_sel)
			3'd1:    extclk_o = fpb_clk_i;
			3'd2:    extclk_o = pll_clk_i;
			3'd3:    extclk_o = rear_clk_i;
			default: extclk_o = 1'b0;         // fpa as source not supported
		endcase
	end

	always_comb begin
		case (extclk_i.fpa_sel)
			2'd0:    fpa_clk_pin_o = '{oe: 1'b1, val: trigger_i};
			2'd1:    fpa_clk_pin_o = '{oe: 1'b1, val: clkgen_i};
			2'd2:    fpa_clk_pin_o = '{oe: 1'b1, val: glitchclk_i};
			default: fpa_clk_pin_o = '{oe: 1'b0, val: 1'b0}; // hi-z, pin usable as input
		endcase
	end

endmodule

//--- logic/cw_io_top.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module cw_io_top (
	input  logic                                  clk,
	input  logic                                  reset,
	input  cw_pkg::cw_reg_bus_t                   bus_i,
	input  logic [`CW_ADDR_W-1:0]                 hyp_addr_i,
	input  logic                                  fpa_i,
	input  logic                                  fpb_i,
	input  logic [`CW_IO_LINES-1:0]               io_trig_i,
	input  logic                                  advio_i,
	input  logic                                  anapattern_i,
	input  logic                                  decodedio_i,
	input  logic                                  fpb_clk_i,
	input  logic                                  pll_clk_i,
	input  logic                                  rear_clk_i,
	input  logic                                  clkgen_i,
	input  logic                                  glitchclk_i,
	input  logic                                  uart_tx_i,
	input  logic                                  usi_out_i,
	input  logic [`CW_IO_LINES-1:0]               io_lines_i,
	output logic [`CW_DATA_W-1:0]                 rd_data_o,
	output logic                                  rd_valid_o,
	output logic [`CW_LEN_W-1:0]                  hyp_len_o,
	output logic                                  trigger_o,
	output logic                                  trig_ext_o,
	output logic                                  extclk_o,
	output cw_pkg::cw_pin_t                       fpa_pin_o,
	output cw_pkg::cw_pin_t                       fpb_pin_o,
	output cw_pkg::cw_pin_t                       fpa_clk_pin_o,
	output cw_pkg::cw_pin_t [`CW_IO_LINES-1:0]    io_pins_o,
	output logic                                  uart_rx_o,
	output logic                                  usi_in_o,
	output cw_pkg::cw_ctrl_pins_t                 ctrl_pins_o,
	output logic                                  power_off_o
);
	import cw_pkg::*;

	cw_extclk_t    extclk_cfg;
	cw_trigsrc_t   trigsrc_cfg;
	cw_trigmod_t   trigmod_cfg;
	cw_route_cfg_t route_cfg;
	logic          lines_hiz;               // power off releases target lines

	cw_reg_ctrl cw_reg_ctrl_i (
		.clk, .reset, .bus_i, .hyp_addr_i, .io_lines_i,
		.rd_data_o, .rd_valid_o, .hyp_len_o,
		.extclk_o(extclk_cfg), .trigsrc_o(trigsrc_cfg),
		.trigmod_o(trigmod_cfg), .route_o(route_cfg)
	);

	trig_combine trig_combine_i (
		.trigsrc_i(trigsrc_cfg), .trigmod_i(trigmod_cfg),
		.fpa_i, .fpb_i, .io_trig_i, .advio_i, .anapattern_i, .decodedio_i,
		.trig_ext_o, .trigger_o, .fpa_pin_o, .fpb_pin_o
	);

	clk_route clk_route_i (
		.extclk_i(extclk_cfg), .trigger_i(trigger_o),
		.fpb_clk_i, .pll_clk_i, .rear_clk_i, .clkgen_i, .glitchclk_i,
		.extclk_o, .fpa_clk_pin_o
	);

	target_power target_power_i (
		.clk, .reset, .extra_i(route_cfg.extra),
		.power_off_o, .lines_hiz_o(lines_hiz)
	);

	target_io_route target_io_route_i (
		.route_i(route_cfg), .lines_hiz_i(lines_hiz),
		.uart_tx_i, .usi_out_i, .io_lines_i,
		.io_pins_o, .uart_rx_o, .usi_in_o, .ctrl_pins_o
	);

endmodule

//--- logic/cw_pkg.sv
`include "cw_params.svh"

package cw_pkg;

	typedef struct packed {
		logic [`CW_ADDR_W-1:0] addr;      // register address
		logic [`CW_CNT_W-1:0]  bytecnt;   // byte index for multi-byte registers
		logic [`CW_DATA_W-1:0] wr_data;
		logic                  rd;        // single-cycle read strobe
		logic                  wr;        // single-cycle write strobe
	} cw_reg_bus_t;

	typedef struct packed {
		logic       spare;
		logic [1:0] rear_src;             // rear clock out source, storage only
		logic [1:0] fpa_sel;              // front panel a drive: trig, clkgen, glitch, hi-z
		logic [2:0] src_sel;              // fabric clock source
	} cw_extclk_t;

	typedef struct packed {
		logic [1:0]               mode;   // 0 or, 1 and, 2 nand
		logic [`CW_TRIG_SRCS-1:0] en;     // line4..line1, fpb, fpa
	} cw_trigsrc_t;

	typedef struct packed {
		logic [2:0] spare;
		logic       fpb_oe;               // drive trigger onto front panel b
		logic       fpa_oe;               // drive trigger onto front panel a
		logic [2:0] mod_sel;              // trigger module
	} cw_trigmod_t;

	typedef struct packed {
		logic gpio_en;                    // drive gpio_state onto the line
		logic gpio_state;
		logic uart_oc;                    // uart tx open collector, line 3 only
		logic usi_oc;                     // usi out open collector, line 3 only
		logic usi_in;                     // line feeds usi in
		logic usi_out;                    // line driven by usi out
		logic uart_rx;                    // line feeds uart rx
		logic uart_tx;                    // line driven by uart tx
	} cw_gpio_route_t;

	typedef struct packed {
		logic [1:0] spare_hi;
		logic [1:0] sc_setup;             // smart-card setup, storage only
		logic       spare_lo;
		logic       fast_start;           // skip the pwm soft start
		logic       power_off;            // target power off request
		logic       prog_en;              // avr programming enable
	} cw_extra_t;

	typedef struct packed {
		logic [1:0] spare;
		logic       pdic;
		logic       pdic_en;
		logic       pdid;
		logic       pdid_en;
		logic       nrst;
		logic       nrst_en;
	} cw_extra_gpio_t;

	typedef struct packed {
		logic [7:0]           reserved;   // byte 7
		cw_extra_gpio_t       extra_gpio; // byte 6
		cw_extra_t            extra;      // byte 5
		logic [7:0]           glitch;     // byte 4, storage only
		cw_gpio_route_t [3:0] gpio;       // bytes 3..0, gpio[0] is line 1
	} cw_route_cfg_t;

	typedef struct packed {
		logic oe;                         // output enable
		logic val;                        // drive value when enabled
	} cw_pin_t;

	typedef struct packed {
		logic    prog_en;
		cw_pin_t nrst;
		cw_pin_t pdid;
		cw_pin_t pdic;
	} cw_ctrl_pins_t;

endpackage

//--- logic/cw_reg_ctrl.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module cw_reg_ctrl (
	input  logic                   clk,
	input  logic                   reset,
	input  cw_pkg::cw_reg_bus_t    bus_i,
	input  logic [`CW_ADDR_W-1:0]  hyp_addr_i,    // length query address
	input  logic [`CW_IO_LINES-1:0] io_lines_i,   // target lines for readback
	output logic [`CW_DATA_W-1:0]  rd_data_o,
	output logic                   rd_valid_o,
	output logic [`CW_LEN_W-1:0]   hyp_len_o,
	output cw_pkg::cw_extclk_t     extclk_o,
	output cw_pkg::cw_trigsrc_t    trigsrc_o,
	output cw_pkg::cw_trigmod_t    trigmod_o,
	output cw_pkg::cw_route_cfg_t  route_o
);
	import cw_pkg::*;

	localparam int SEL_W = $clog2(`CW_ROUTE_BYTES);

	cw_extclk_t              extclk_q;
	cw_trigsrc_t             trigsrc_q;
	cw_trigmod_t             trigmod_q;
	cw_route_cfg_t           route_q;
	logic [`CW_IO_LINES-1:0] ioread_q;     // sampled target lines
	logic [`CW_DATA_W-1:0]   rd_data_q;
	logic                    rd_valid_q;
	logic                    rd_hit;       // address is a known register
	logic [SEL_W-1:0]        byte_sel;     // routing byte lane

	assign byte_sel = bus_i.bytecnt[SEL_W-1:0];

	always_comb begin
		case (bus_i.addr)
			`CW_EXTCLK_ADDR,
			`CW_TRIGSRC_ADDR,
			`CW_TRIGMOD_ADDR,
			`CW_IOROUTE_ADDR,
			`CW_IOREAD_ADDR: rd_hit = 1'b1;
			default:         rd_hit = 1'b0;
		endcase
	end

	// register writes, readback address has no storage to write
	always_ff @(posedge clk) begin
		if (reset) begin
			extclk_q  <= `CW_EXTCLK_RST;
			trigsrc_q <= `CW_TRIGSRC_RST;
			trigmod_q <= `CW_TRIGMOD_RST;
			route_q   <= `CW_ROUTE_RST;
		end else if (bus_i.wr) begin
			case (bus_i.addr)
				`CW_EXTCLK_ADDR:  extclk_q  <= bus_i.wr_data;
				`CW_TRIGSRC_ADDR: trigsrc_q <= bus_i.wr_data;
				`CW_TRIGMOD_ADDR: trigmod_q <= bus_i.wr_data;
				`CW_IOROUTE_ADDR: route_q[byte_sel*`CW_DATA_W +: `CW_DATA_W] <= bus_i.wr_data;
				default: ;                       // readback and unknown addresses ignored
			endcase
		end
	end

	// target lines sampled every clock
	always_ff @(posedge clk) begin
		if (reset) begin
			ioread_q <= '0;
		end else begin
			ioread_q <= io_lines_i;
		end
	end

	// read data captured on the strobe edge, cleared when no read is answered
	always_ff @(posedge clk) begin
		if (reset || !bus_i.rd) begin
			rd_data_q <= '0;
		end else begin
			case (bus_i.addr)
				`CW_EXTCLK_ADDR:  rd_data_q <= extclk_q;
				`CW_TRIGSRC_ADDR: rd_data_q <= trigsrc_q;
				`CW_TRIGMOD_ADDR: rd_data_q <= trigmod_q;
				`CW_IOROUTE_ADDR: rd_data_q <= route_q[byte_sel*`CW_DATA_W +: `CW_DATA_W];
				`CW_IOREAD_ADDR:  rd_data_q <= `CW_DATA_W'(ioread_q); // lines in bits 3:0
				default:          rd_data_q <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= bus_i.rd & rd_hit;     // valid only for the cycle after the strobe
		end
	end

	assign rd_valid_o = rd_valid_q;
	assign rd_data_o  = rd_data_q;               // bus reads zero when idle

	// length lookup, combinational from the query address
	always_comb begin
		case (hyp_addr_i)
			`CW_EXTCLK_ADDR,
			`CW_TRIGSRC_ADDR,
			`CW_TRIGMOD_ADDR,
			`CW_IOREAD_ADDR:  hyp_len_o = `CW_LEN_W'(1);
			`CW_IOROUTE_ADDR: hyp_len_o = `CW_LEN_W'(`CW_ROUTE_BYTES);
			default:          hyp_len_o = '0;
		endcase
	end

	assign extclk_o  = extclk_q;
	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign route_o   = route_q;

endmodule

//--- logic/target_io_route.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module target_io_route (
	input  cw_pkg::cw_route_cfg_t                 route_i,
	input  logic                                  lines_hiz_i,  // target power off
	input  logic                                  uart_tx_i,
	input  logic                                  usi_out_i,
	input  logic [`CW_IO_LINES-1:0]               io_lines_i,   // line input side
	output cw_pkg::cw_pin_t [`CW_IO_LINES-1:0]    io_pins_o,
	output logic                                  uart_rx_o,
	output logic                                  usi_in_o,
	output cw_pkg::cw_ctrl_pins_t                 ctrl_pins_o
);
	import cw_pkg::*;

	localparam int RX_LINES = 3;             // line 4 has no receive path
	localparam int OC_LINE  = 2;             // line 3 carries the open-collector modes

	// drive priority for one line, lower bits of the route byte win
	function automatic cw_pin_t route_line(input cw_gpio_route_t cfg, input logic usi_ok,
			input logic oc_ok, input logic tx, input logic usi);
		cw_pin_t pin;
		pin = '{oe: 1'b0, val: 1'b0};        // released
		if (cfg.uart_tx) begin
			pin = '{oe: 1'b1, val: tx};
		end else if (usi_ok && cfg.usi_out) begin
			pin = '{oe: 1'b1, val: usi};
		end else if (oc_ok && cfg.usi_oc) begin
			pin = '{oe: ~usi, val: 1'b0};    // pull low only
		end else if (oc_ok && cfg.uart_oc) begin
			pin = '{oe: ~tx, val: 1'b0};
		end else if (cfg.gpio_en) begin
			pin = '{oe: 1'b1, val: cfg.gpio_state};
		end
		return pin;
	endfunction

	for (genvar i = 0; i < `CW_IO_LINES; i++) begin : g_line
		assign io_pins_o[i] = lines_hiz_i ? cw_pin_t'('0) :
			route_line(route_i.gpio[i], 1'(i < RX_LINES), 1'(i == OC_LINE),
				uart_tx_i, usi_out_i);
	end

	// receive selects, lowest numbered line wins, idle high
	always_comb begin
		uart_rx_o = 1'b1;
		usi_in_o  = 1'b1;
		for (int i = RX_LINES - 1; i >= 0; i--) begin
			if (route_i.gpio[i].uart_rx) begin
				uart_rx_o = io_lines_i[i];
			end
			if (route_i.gpio[i].usi_in) begin
				usi_in_o = io_lines_i[i];
			end
		end
	end

	// programming and gpio-style control pins
	assign ctrl_pins_o.prog_en = route_i.extra.prog_en;
	assign ctrl_pins_o.nrst    = '{oe: route_i.extra_gpio.nrst_en, val: route_i.extra_gpio.nrst};
	assign ctrl_pins_o.pdid    = '{oe: route_i.extra_gpio.pdid_en, val: route_i.extra_gpio.pdid};
	assign ctrl_pins_o.pdic    = '{oe: route_i.extra_gpio.pdic_en, val: route_i.extra_gpio.pdic};

endmodule

//--- logic/target_power.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module target_power (
	input  logic              clk,
	input  logic              reset,
	input  cw_pkg::cw_extra_t extra_i,
	output logic              power_off_o,   // target power switch, 1 is off
	output logic              lines_hiz_o    // release target lines while off
);
	import cw_pkg::*;

	logic                  power_q;          // registered power-off bit
	logic                  power_prev_q;     // for off-to-on edge
	logic                  soft_on_q;        // soft start armed
	logic [`CW_PWM_W-1:0]  pwm_cnt_q;        // free-running pwm
	logic [`CW_SOFT_W-1:0] soft_cnt_q;       // pwm periods into the ramp
	logic                  ramp_active;
	logic                  pwm_off;

	always_ff @(posedge clk) begin
		if (reset) begin
			power_q      <= 1'b0;
			power_prev_q <= 1'b0;
			pwm_cnt_q    <= '0;
		end else begin
			power_q      <= extra_i.power_off;
			power_prev_q <= power_q;
			pwm_cnt_q    <= pwm_cnt_q + 1'b1;
		end
	end

	// arm on off-to-on change with slow start, any off request disarms
	always_ff @(posedge clk) begin
		if (reset) begin
			soft_on_q <= 1'b0;
		end else if (power_q) begin
			soft_on_q <= 1'b0;
		end else if (power_prev_q && !extra_i.fast_start) begin
			soft_on_q <= 1'b1;
		end else if (soft_cnt_q == '1) begin
			soft_on_q <= 1'b0;               // ramp finished
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !soft_on_q) begin
			soft_cnt_q <= '0;
		end else if (pwm_cnt_q == '0 && soft_cnt_q != '1) begin
			soft_cnt_q <= soft_cnt_q + 1'b1; // one step per pwm period
		end
	end

	assign ramp_active = soft_on_q && (soft_cnt_q != '1);
	assign pwm_off     = (pwm_cnt_q < `CW_PWM_W'(`CW_PWM_OFF));

	assign power_off_o = power_q | (ramp_active & pwm_off);
	assign lines_hiz_o = power_q;

endmodule

//--- logic/trig_combine.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module trig_combine (
	input  cw_pkg::cw_trigsrc_t     trigsrc_i,
	input  cw_pkg::cw_trigmod_t     trigmod_i,
	input  logic                    fpa_i,         // front panel a input side
	input  logic                    fpb_i,         // front panel b input side
	input  logic [`CW_IO_LINES-1:0] io_trig_i,     // target lines 4..1
	input  logic                    advio_i,       // advanced io module
	input  logic                    anapattern_i,  // analog pattern module
	input  logic                    decodedio_i,   // decoded io module
	output logic                    trig_ext_o,    // combined external trigger
	output logic                    trigger_o,     // selected module trigger
	output cw_pkg::cw_pin_t         fpa_pin_o,
	output cw_pkg::cw_pin_t         fpb_pin_o
);
	import cw_pkg::*;

	logic [`CW_TRIG_SRCS-1:0] src;       // same bit order as the enable field
	logic                     trig_or;
	logic                     trig_and;

	assign src = {io_trig_i, fpb_i, fpa_i};

	assign trig_or  = |(trigsrc_i.en & src);
	assign trig_and = &(~trigsrc_i.en | src); // disabled sources read as true

	always_comb begin
		case (trigsrc_i.mode)
			2'd0:    trig_ext_o = trig_or;
			2'd1:    trig_ext_o = trig_and;
			2'd2:    trig_ext_o = ~trig_and;
			default: trig_ext_o = 1'b0;
		endcase
	end

	// module select
	always_comb begin
		case (trigmod_i.mod_sel)
			3'd0:    trigger_o = trig_ext_o;
			3'd1:    trigger_o = advio_i;
			3'd2:    trigger_o = anapattern_i;
			3'd3:    trigger_o = decodedio_i;
			default: trigger_o = 1'b0;
		endcase
	end

	// front panel pins carry the final trigger when enabled
	assign fpa_pin_o = '{oe: trigmod_i.fpa_oe, val: trigger_o};
	assign fpb_pin_o = '{oe: trigmod_i.fpb_oe, val: trigger_o};

endmodule

//--- project.f
+incdir+include
logic/cw_pkg.sv
logic/cw_reg_ctrl.sv
logic/trig_combine.sv
logic/clk_route.sv
logic/target_power.sv
logic/target_io_route.sv
logic/cw_io_top.sv
testbench/cw_io_chk.sv
testbench/cw_io_tb.sv

//--- testbench/cw_io_chk.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module cw_io_chk (
	input logic                  clk,
	input logic                  reset,
	input cw_pkg::cw_reg_bus_t   bus_i,
	input logic [`CW_ADDR_W-1:0] hyp_addr_i,
	input logic [`CW_DATA_W-1:0] rd_data_o,
	input logic                  rd_valid_o,
	input logic [`CW_LEN_W-1:0]  hyp_len_o
);
	import cw_pkg::*;

	logic listed;                        // query address is a known register

	assign listed = hyp_addr_i inside {`CW_EXTCLK_ADDR, `CW_TRIGSRC_ADDR, `CW_TRIGMOD_ADDR,
		`CW_IOROUTE_ADDR, `CW_IOREAD_ADDR};

	// valid only follows a read strobe
	valid_after_strobe: assert property (@(posedge clk) disable iff (reset)
		$rose(rd_valid_o) |-> $past(bus_i.rd))
		else $error("rd_valid_o rose without a read strobe");

	idle_data_zero: assert property (@(posedge clk) disable iff (reset)
		!rd_valid_o |-> (rd_data_o == '0))
		else $error("rd_data_o not zero while idle");

	unlisted_len_zero: assert property (@(posedge clk) disable iff (reset)
		!listed |-> (hyp_len_o == '0))
		else $error("hyp_len_o not zero for unlisted address");

endmodule

bind cw_reg_ctrl cw_io_chk cw_io_chk_i (
	.clk, .reset, .bus_i, .hyp_addr_i, .rd_data_o, .rd_valid_o, .hyp_len_o
);

//--- testbench/cw_io_tb.sv
`timescale 1ns/1ns
`include "cw_params.svh"

module cw_io_tb;
	import cw_pkg::*;

	// rough cycle budget per test group
	localparam int TEST_CYCLES = 20 + 120 + 40 * 8 + 32 * 3 + 24 * 18 + 200;
	localparam int PWM_PERIOD  = 1 << `CW_PWM_W;

	logic                    clk;
	logic                    reset;
	cw_reg_bus_t             bus;
	logic [`CW_ADDR_W-1:0]   hyp_addr;
	logic                    fpa, fpb, advio, anapattern, decodedio;
	logic [`CW_IO_LINES-1:0] io_trig;
	logic                    fpb_clk, pll_clk, rear_clk, clkgen, glitchclk;
	logic                    uart_tx, usi_out;
	logic [`CW_IO_LINES-1:0] io_lines;
	logic [`CW_DATA_W-1:0]   rd_data;
	logic                    rd_valid;
	logic [`CW_LEN_W-1:0]    hyp_len;
	logic                    trigger, trig_ext, extclk, power_off;
	cw_pin_t                 fpa_pin, fpb_pin, fpa_clk_pin;
	cw_pin_t [`CW_IO_LINES-1:0] io_pins;
	logic                    uart_rx, usi_in;
	cw_ctrl_pins_t           ctrl_pins;

	// shadow copy of the register file
	cw_extclk_t    sh_extclk;
	cw_trigsrc_t   sh_trigsrc;
	cw_trigmod_t   sh_trigmod;
	cw_route_cfg_t sh_route;
	logic          pwr_seen;              // power bit as the lines see it
	logic          cmp_en;
	int            errors;
	int            checks;
	integer        seed;
	logic [31:0]   rnd;

	cw_io_top cw_io_top_i (
		.clk, .reset, .bus_i(bus), .hyp_addr_i(hyp_addr),
		.fpa_i(fpa), .fpb_i(fpb), .io_trig_i(io_trig), .advio_i(advio),
		.anapattern_i(anapattern), .decodedio_i(decodedio),
		.fpb_clk_i(fpb_clk), .pll_clk_i(pll_clk), .rear_clk_i(rear_clk),
		.clkgen_i(clkgen), .glitchclk_i(glitchclk),
		.uart_tx_i(uart_tx), .usi_out_i(usi_out), .io_lines_i(io_lines),
		.rd_data_o(rd_data), .rd_valid_o(rd_valid), .hyp_len_o(hyp_len),
		.trigger_o(trigger), .trig_ext_o(trig_ext), .extclk_o(extclk),
		.fpa_pin_o(fpa_pin), .fpb_pin_o(fpb_pin), .fpa_clk_pin_o(fpa_clk_pin),
		.io_pins_o(io_pins), .uart_rx_o(uart_rx), .usi_in_o(usi_in),
		.ctrl_pins_o(ctrl_pins), .power_off_o(power_off)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(TEST_CYCLES * 8 + 2000);
		$display("timeout: tests did not finish in the cycle budget");
		$display("Checks failed");
		$finish;
	end

	task automatic byte_cmp(input string name, input logic [`CW_DATA_W-1:0] exp,
			input logic [`CW_DATA_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic pin_cmp(input string name, input cw_pin_t exp, input cw_pin_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic len_cmp(input string name, input logic [`CW_LEN_W-1:0] exp,
			input logic [`CW_LEN_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic bit_cmp(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %b actual %b", name, exp, act);
		end
	endtask

	// length table
	function automatic logic [`CW_LEN_W-1:0] exp_len(input logic [`CW_ADDR_W-1:0] a);
		case (a)
			6'd38, 6'd39, 6'd40, 6'd59: return 16'd1;
			6'd55:                      return 16'd8;
			default:                    return 16'd0;
		endcase
	endfunction

	function automatic logic [`CW_DATA_W-1:0] exp_reg(input logic [`CW_ADDR_W-1:0] a,
			input logic [2:0] lane);
		case (a)
			6'd38:   return sh_extclk;
			6'd39:   return sh_trigsrc;
			6'd40:   return sh_trigmod;
			6'd55:   return sh_route[lane*8 +: 8];
			default: return 8'h00;
		endcase
	endfunction

	// combine rules applied to the enabled sources only
	function automatic logic exp_trig_ext(input cw_trigsrc_t ts,
			input logic [`CW_TRIG_SRCS-1:0] src);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1;                         // unenabled source counts as true
		for (int i = 0; i < `CW_TRIG_SRCS; i++) begin
			if (ts.en[i]) begin
				any_hi = any_hi | src[i];
				all_hi = all_hi & src[i];
			end
		end
		case (ts.mode)
			2'd0:    return any_hi;
			2'd1:    return all_hi;
			2'd2:    return ~all_hi;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic exp_trigger(input cw_trigmod_t tm, input logic ext);
		case (tm.mod_sel)
			3'd0:    return ext;
			3'd1:    return advio;
			3'd2:    return anapattern;
			3'd3:    return decodedio;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic exp_extclk(input cw_extclk_t ec);
		case (ec.src_sel)
			3'd1:    return fpb_clk;
			3'd2:    return pll_clk;
			3'd3:    return rear_clk;
			default: return 1'b0;
		endcase
	endfunction

	function automatic cw_pin_t exp_fpa_clk(input cw_extclk_t ec, input logic trig);
		case (ec.fpa_sel)
			2'd0:    return '{oe: 1'b1, val: trig};
			2'd1:    return '{oe: 1'b1, val: clkgen};
			2'd2:    return '{oe: 1'b1, val: glitchclk};
			default: return '{oe: 1'b0, val: 1'b0};
		endcase
	endfunction

	// line drive rules, idx 0 is line 1
	function automatic cw_pin_t exp_line(input int idx, input cw_gpio_route_t c, input logic hiz);
		if (hiz)
			return '{oe: 1'b0, val: 1'b0};
		if (c.uart_tx)
			return '{oe: 1'b1, val: uart_tx};
		if (idx < 3 && c.usi_out)
			return '{oe: 1'b1, val: usi_out};
		if (idx == 2 && c.usi_oc)
			return '{oe: ~usi_out, val: 1'b0};
		if (idx == 2 && c.uart_oc)
			return '{oe: ~uart_tx, val: 1'b0};
		if (c.gpio_en)
			return '{oe: 1'b1, val: c.gpio_state};
		return '{oe: 1'b0, val: 1'b0};
	endfunction

	function automatic logic exp_rx(input logic usi_sel);
		for (int i = 0; i < 3; i++) begin
			if (usi_sel ? sh_route.gpio[i].usi_in : sh_route.gpio[i].uart_rx)
				return io_lines[i];
		end
		return 1'b1;                           // idle high
	endfunction

	// combinational outputs checked every cycle away from the edges
	always @(negedge clk) begin
		if (cmp_en) begin
			logic ext;
			logic trg;
			ext = exp_trig_ext(sh_trigsrc, {io_trig, fpb, fpa});
			trg = exp_trigger(sh_trigmod, ext);
			bit_cmp("trig_ext", ext, trig_ext);
			bit_cmp("trigger", trg, trigger);
			pin_cmp("fpa_pin", '{oe: sh_trigmod.fpa_oe, val: trg}, fpa_pin);
			pin_cmp("fpb_pin", '{oe: sh_trigmod.fpb_oe, val: trg}, fpb_pin);
			bit_cmp("extclk", exp_extclk(sh_extclk), extclk);
			pin_cmp("fpa_clk_pin", exp_fpa_clk(sh_extclk, trg), fpa_clk_pin);
			for (int i = 0; i < `CW_IO_LINES; i++)
				pin_cmp($sformatf("io_pin%0d", i + 1), exp_line(i, sh_route.gpio[i], pwr_seen),
					io_pins[i]);
			bit_cmp("uart_rx", exp_rx(1'b0), uart_rx);
			bit_cmp("usi_in", exp_rx(1'b1), usi_in);
			bit_cmp("prog_en", sh_route.extra.prog_en, ctrl_pins.prog_en);
			pin_cmp("nrst", '{oe: sh_route.extra_gpio.nrst_en, val: sh_route.extra_gpio.nrst},
				ctrl_pins.nrst);
			pin_cmp("pdid", '{oe: sh_route.extra_gpio.pdid_en, val: sh_route.extra_gpio.pdid},
				ctrl_pins.pdid);
			pin_cmp("pdic", '{oe: sh_route.extra_gpio.pdic_en, val: sh_route.extra_gpio.pdic},
				ctrl_pins.pdic);
			len_cmp("hyp_len", exp_len(hyp_addr), hyp_len);
		end
		pwr_seen = sh_route.extra.power_off;   // lines follow one cycle late
	end

	task automatic write_reg(input logic [`CW_ADDR_W-1:0] addr, input logic [2:0] lane,
			input logic [`CW_DATA_W-1:0] data);
		@(posedge clk);
		bus <= '{addr: addr, bytecnt: 16'(lane), wr_data: data, rd: 1'b0, wr: 1'b1};
		@(posedge clk);
		bus <= '0;
		case (addr)
			6'd38:   sh_extclk = data;
			6'd39:   sh_trigsrc = data;
			6'd40:   sh_trigmod = data;
			6'd55:   sh_route[lane*8 +: 8] = data;
			default: ;
		endcase
	endtask

	task automatic read_reg(input string name, input logic [`CW_ADDR_W-1:0] addr,
			input logic [2:0] lane, input logic exp_valid, input logic [`CW_DATA_W-1:0] exp);
		@(posedge clk);
		bus <= '{addr: addr, bytecnt: 16'(lane), wr_data: 8'h00, rd: 1'b1, wr: 1'b0};
		@(posedge clk);
		bus <= '0;
		@(negedge clk);
		bit_cmp({name, "_valid"}, exp_valid, rd_valid);
		byte_cmp(name, exp, rd_data);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	initial begin
		int falls;
		logic prev;
		seed = 5;
		errors = 0;
		checks = 0;
		cmp_en = 1'b0;
		reset = 1'b1;
		bus = '0;
		hyp_addr = '0;
		{fpa, fpb, advio, anapattern, decodedio} = '0;
		io_trig = '0;
		{fpb_clk, pll_clk, rear_clk, clkgen, glitchclk} = '0;
		uart_tx = 1'b1;
		usi_out = 1'b1;
		io_lines = '0;
		sh_extclk = `CW_EXTCLK_RST;
		sh_trigsrc = `CW_TRIGSRC_RST;
		sh_trigmod = `CW_TRIGMOD_RST;
		sh_route = `CW_ROUTE_RST;
		pwr_seen = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		cmp_en = 1'b1;

		// reset values, one-cycle read latency
		read_reg("rst_extclk", 6'd38, 3'd0, 1'b1, 8'h03);
		read_reg("rst_trigsrc", 6'd39, 3'd0, 1'b1, 8'h01);
		read_reg("rst_trigmod", 6'd40, 3'd0, 1'b1, 8'h00);
		read_reg("rst_route0", 6'd55, 3'd0, 1'b1, 8'h01);
		read_reg("rst_route1", 6'd55, 3'd1, 1'b1, 8'h02);
		read_reg("rst_ioread", 6'd59, 3'd0, 1'b1, 8'h00);
		read_reg("unlisted", 6'd10, 3'd0, 1'b0, 8'h00);

		// writes, readback and lengths
		for (int b = 0; b < `CW_ROUTE_BYTES; b++) begin
			rnd = $random(seed);
			write_reg(6'd55, 3'(b), rnd[7:0]);
		end
		for (int b = 0; b < `CW_ROUTE_BYTES; b++)
			read_reg($sformatf("route%0d", b), 6'd55, 3'(b), 1'b1, exp_reg(6'd55, 3'(b)));
		for (int a = 38; a <= 40; a++) begin
			rnd = $random(seed);
			write_reg(6'(a), 3'd0, rnd[7:0]);
			read_reg($sformatf("reg%0d", a), 6'(a), 3'd0, 1'b1, exp_reg(6'(a), 3'd0));
		end
		write_reg(6'd59, 3'd0, 8'hff);         // ignored
		read_reg("ioread_wr", 6'd59, 3'd0, 1'b1, 8'h00);
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			@(posedge clk);
			case (i)
				0:       hyp_addr <= 6'd38;
				1:       hyp_addr <= 6'd39;
				2:       hyp_addr <= 6'd40;
				3:       hyp_addr <= 6'd55;
				4:       hyp_addr <= 6'd59;
				default: hyp_addr <= rnd[5:0];
			endcase
		end

		// trigger path
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			write_reg(6'd39, 3'd0, rnd[7:0]);
			write_reg(6'd40, 3'd0, rnd[15:8]);
			@(posedge clk);
			{fpa, fpb, advio, anapattern, decodedio} <= rnd[20:16];
			io_trig <= rnd[24:21];
			wait_cycles(2);
		end

		// clock routing, every select value
		for (int s = 0; s < 32; s++) begin
			rnd = $random(seed);
			write_reg(6'd38, 3'd0, {rnd[7:5], 5'(s)});
			@(posedge clk);
			{fpb_clk, pll_clk, rear_clk, clkgen, glitchclk} <= rnd[12:8];
			wait_cycles(1);
		end

		// target i/o routing and readback
		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			for (int b = 0; b < 4; b++)
				write_reg(6'd55, 3'(b), rnd[b*8 +: 8]);
			rnd = $random(seed);
			write_reg(6'd55, 3'd5, (i % 8 == 7) ? (rnd[7:0] | 8'h02) : (rnd[7:0] & 8'hfd));
			write_reg(6'd55, 3'd6, rnd[15:8]);
			@(posedge clk);
			io_lines <= rnd[19:16];
			uart_tx <= rnd[20];
			usi_out <= rnd[21];
			wait_cycles(2);
			read_reg("ioread", 6'd59, 3'd0, 1'b1, {4'h0, io_lines});
		end

		// power off, then slow start
		write_reg(6'd55, 3'd5, 8'h02);
		@(posedge clk);
		@(negedge clk);
		bit_cmp("power_off", 1'b1, power_off);
		write_reg(6'd55, 3'd5, 8'h00);
		@(posedge clk);
		@(negedge clk);                        // power bit has dropped, ramp not yet armed
		falls = 0;
		prev = power_off;
		repeat (8 * PWM_PERIOD + 1) begin
			@(negedge clk);
			if (prev && !power_off)
				falls++;
			prev = power_off;
		end
		checks++;
		if (falls == 0) begin
			errors++;
			$display("soft start produced no PWM pulse on power_off_o");
		end
		repeat (PWM_PERIOD) begin
			@(negedge clk);
			bit_cmp("power_steady", 1'b0, power_off);
		end

		// fast start, no pwm pulse over a full period
		write_reg(6'd55, 3'd5, 8'h02);
		wait_cycles(3);
		write_reg(6'd55, 3'd5, 8'h04);
		@(posedge clk);
		repeat (PWM_PERIOD + 2) begin
			@(negedge clk);
			bit_cmp("power_fast", 1'b0, power_off);
		end

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
